/* rtl/bch_pkg.sv */
package bch_pkg;

	localparam int FIELD_M = 4;
	localparam int CODE_N = 15;
	localparam int DATA_K = 5;
	localparam int MAX_T = 3;

	localparam logic [FIELD_M:0] PRIM_POLY = 5'b10011; // x^4 + x + 1.
	localparam logic [CODE_N-DATA_K:0] GEN_POLY = 11'b101_0011_0111;

	// two cycles per Berlekamp-Massey iteration.
	localparam int KEY_CYCLES = 2 * MAX_T;

	typedef logic [FIELD_M-1:0] gf_t;
	typedef logic [DATA_K-1:0] data_t;
	typedef logic [CODE_N-1:0] code_t; // bit 14 goes out first.
	typedef logic [$clog2(MAX_T+1)-1:0] count_t;

	typedef struct packed {
		gf_t s5;
		gf_t s3;
		gf_t s1;
	} syndromes_t;

	typedef struct packed {
		gf_t sigma3;
		gf_t sigma2;
		gf_t sigma1;
		gf_t sigma0;
	} sigma_t;

	typedef struct packed {
		syndromes_t syn;
		code_t word;
	} syn_result_t;

	typedef struct packed {
		sigma_t sigma;
		count_t count;
		logic present;
		code_t word;
	} key_result_t;

	typedef struct packed {
		data_t data;
		count_t count;
		logic present;
		logic fail;
	} dec_result_t;

	// shift and add, reducing by the field polynomial.
	function automatic gf_t gf_mul(gf_t a, gf_t b);
		gf_t p;
		gf_t sh;
		p = '0;
		sh = a;
		for (int i = 0; i < FIELD_M; i++) begin
			if (b[i])
				p ^= sh;
			sh = {sh[FIELD_M-2:0], 1'b0} ^ (sh[FIELD_M-1] ? PRIM_POLY[FIELD_M-1:0] : '0);
		end
		return p;
	endfunction

	function automatic gf_t gf_alpha(int p);
		gf_t a;
		a = gf_t'(1);
		for (int i = 0; i < CODE_N; i++) begin
			if (i < p % CODE_N)
				a = gf_mul(a, gf_t'(2));
		end
		return a;
	endfunction

endpackage

/* rtl/bch_encode.sv */
module bch_encode import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input data_t data_in,
	output logic busy,
	output logic bit_valid,
	output logic code_bit
);

	localparam int PAR_N = CODE_N - DATA_K;

	logic [3:0] cnt;
	data_t data_r;
	logic [PAR_N-1:0] lfsr;
	logic in_data;
	logic fb;

	assign in_data = (cnt < 4'(DATA_K));
	assign fb = data_r[DATA_K-1] ^ lfsr[PAR_N-1];

	// data bits first, then the remainder.
	assign code_bit = in_data ? data_r[DATA_K-1] : lfsr[PAR_N-1];
	assign bit_valid = busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (start && !busy) begin
			busy <= 1'b1;
			cnt <= '0;
		end else if (busy) begin
			cnt <= cnt + 4'd1;
			if (cnt == 4'(CODE_N - 1))
				busy <= 1'b0; // last bit is on the line.
		end
	end

	always_ff @(posedge clk) begin
		if (start && !busy) begin
			data_r <= data_in;
			lfsr <= '0;
		end else if (busy) begin
			if (in_data) begin
				data_r <= {data_r[DATA_K-2:0], 1'b0};
				lfsr <= {lfsr[PAR_N-2:0], 1'b0} ^ (fb ? GEN_POLY[PAR_N-1:0] : '0);
			end else begin
				lfsr <= {lfsr[PAR_N-2:0], 1'b0}; // parity out, msb first.
			end
		end
	end

endmodule

/* rtl/bch_syndrome.sv */
module bch_syndrome import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic rx_valid,
	input logic rx_bit,
	output logic syn_done,
	output syn_result_t syn_out
);

	logic [3:0] pos;
	logic first;
	logic last;
	gf_t s1;
	gf_t s3;
	gf_t s5;
	code_t word;

	// one Horner step, dropping the old value on the first bit.
	function automatic gf_t horner(gf_t acc, int root, logic clear, logic b);
		gf_t nxt;
		nxt = clear ? '0 : gf_mul(acc, gf_alpha(root));
		return nxt ^ {{(FIELD_M-1){1'b0}}, b};
	endfunction

	assign first = (pos == 4'd0);
	assign last = (pos == 4'(CODE_N - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			pos <= '0;
			syn_done <= 1'b0;
		end else begin
			syn_done <= rx_valid && last;
			if (rx_valid)
				pos <= last ? 4'd0 : pos + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rx_valid) begin
			s1 <= horner(s1, 1, first, rx_bit);
			s3 <= horner(s3, 3, first, rx_bit);
			s5 <= horner(s5, 5, first, rx_bit);
			word <= {word[CODE_N-2:0], rx_bit}; // first bit lands in bit 14.
		end
	end

	always_comb begin
		syn_out.syn.s1 = s1;
		syn_out.syn.s3 = s3;
		syn_out.syn.s5 = s5;
		syn_out.word = word;
	end

endmodule

/* rtl/bch_key.sv */
module bch_key import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic syn_done,
	input syn_result_t syn_in,
	output logic key_done,
	output key_result_t key_out
);

	typedef enum logic {
		KEY_IDLE,
		KEY_ITER
	} state_t;

	state_t state;
	logic [2:0] step;
	logic [1:0] r;
	gf_t syn_r [1:2*MAX_T-1];
	gf_t lam [0:MAX_T];
	gf_t beta [0:MAX_T];
	gf_t gamma;
	gf_t d;
	gf_t disc;
	gf_t s2;
	logic [2:0] len;
	logic jump;
	logic present_r;
	code_t word_r;

	assign r = step[2:1]; // iteration number.
	assign s2 = gf_mul(syn_in.syn.s1, syn_in.syn.s1);

	// length change when the discrepancy is nonzero and 2L <= 2r.
	assign jump = (d != '0) && (len <= {1'b0, r});

	always_comb begin : discrepancy
		int idx;
		disc = '0;
		for (int i = 0; i <= MAX_T; i++) begin
			idx = 2 * int'(r) + 1 - i;
			if (idx >= 1)
				disc ^= gf_mul(lam[i], syn_r[idx]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= KEY_IDLE;
			step <= '0;
			key_done <= 1'b0;
		end else begin
			key_done <= 1'b0;
			case (state)
				KEY_IDLE: begin
					if (syn_done) begin
						state <= KEY_ITER;
						step <= 3'd1; // capture already computed the first discrepancy.
					end
				end
				KEY_ITER: begin
					step <= step + 3'd1;
					if (step == 3'(KEY_CYCLES - 1)) begin
						state <= KEY_IDLE;
						key_done <= 1'b1;
					end
				end
				default: state <= KEY_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == KEY_IDLE && syn_done) begin
			syn_r[1] <= syn_in.syn.s1;
			syn_r[2] <= s2;
			syn_r[3] <= syn_in.syn.s3;
			syn_r[4] <= gf_mul(s2, s2);
			syn_r[5] <= syn_in.syn.s5;
			for (int i = 0; i <= MAX_T; i++) begin
				lam[i] <= (i == 0) ? gf_t'(1) : '0;
				beta[i] <= (i == 1) ? gf_t'(1) : '0; // beta starts as x.
			end
			gamma <= gf_t'(1);
			d <= syn_in.syn.s1;
			len <= '0;
			present_r <= |syn_in.syn;
			word_r <= syn_in.word;
		end else if (state == KEY_ITER) begin
			if (!step[0]) begin
				d <= disc;
			end else begin
				for (int i = 0; i <= MAX_T; i++)
					lam[i] <= gf_mul(gamma, lam[i]) ^ gf_mul(d, beta[i]);
				beta[0] <= '0;
				beta[1] <= '0;
				for (int i = 2; i <= MAX_T; i++)
					beta[i] <= jump ? lam[i-2] : beta[i-2];
				if (jump) begin
					len <= {r, 1'b1} - len;
					gamma <= d;
				end
			end
		end
	end

	always_comb begin
		key_out.sigma.sigma0 = lam[0];
		key_out.sigma.sigma1 = lam[1];
		key_out.sigma.sigma2 = lam[2];
		key_out.sigma.sigma3 = lam[3];
		// a length above T only comes from an uncorrectable word.
		key_out.count = (len > 3'(MAX_T)) ? count_t'(MAX_T) : count_t'(len);
		key_out.present = present_r;
		key_out.word = word_r;
	end

endmodule

/* rtl/bch_chien.sv */
module bch_chien import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic key_done,
	input key_result_t key_in,
	output logic done,
	output dec_result_t result
);

	typedef enum logic [1:0] {
		CH_IDLE,
		CH_SEARCH,
		CH_REPORT
	} state_t;

	state_t state;
	logic [3:0] pos;
	logic [3:0] roots;
	gf_t s0_r;
	gf_t term_r [1:MAX_T];
	count_t count_r;
	logic present_r;
	code_t word_r;

	gf_t key_coef [1:MAX_T];
	gf_t cur_term [1:MAX_T];
	gf_t cur_s0;
	code_t cur_word;
	logic [3:0] cur_pos;
	gf_t sum;
	logic hit;
	logic eval;

	assign key_coef[1] = key_in.sigma.sigma1;
	assign key_coef[2] = key_in.sigma.sigma2;
	assign key_coef[3] = key_in.sigma.sigma3;

	assign eval = (state == CH_IDLE && key_done) || state == CH_SEARCH;

	// the capture cycle already tests position 14.
	always_comb begin
		if (state == CH_IDLE) begin
			cur_s0 = key_in.sigma.sigma0;
			for (int j = 1; j <= MAX_T; j++)
				cur_term[j] = gf_mul(key_coef[j], gf_alpha(j));
			cur_word = key_in.word;
			cur_pos = 4'(CODE_N - 1);
		end else begin
			cur_s0 = s0_r;
			for (int j = 1; j <= MAX_T; j++)
				cur_term[j] = term_r[j];
			cur_word = word_r;
			cur_pos = pos;
		end
		sum = cur_s0;
		for (int j = 1; j <= MAX_T; j++)
			sum ^= cur_term[j];
		hit = (sum == '0); // locator vanishes at alpha^-pos.
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= CH_IDLE;
			pos <= '0;
			roots <= '0;
			done <= 1'b0;
			result <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				CH_IDLE: begin
					if (key_done) begin
						state <= CH_SEARCH;
						pos <= 4'(CODE_N - 2);
						roots <= {3'b000, hit};
					end
				end
				CH_SEARCH: begin
					roots <= roots + {3'b000, hit};
					if (pos == 4'd0)
						state <= CH_REPORT;
					else
						pos <= pos - 4'd1;
				end
				CH_REPORT: begin
					done <= 1'b1;
					result.data <= word_r[CODE_N-1 -: DATA_K];
					result.count <= count_r;
					result.present <= present_r;
					result.fail <= (roots != {2'b00, count_r});
					state <= CH_IDLE;
				end
				default: state <= CH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (eval) begin
			for (int j = 1; j <= MAX_T; j++)
				term_r[j] <= gf_mul(cur_term[j], gf_alpha(j));
			word_r <= cur_word ^ (code_t'(hit) << cur_pos);
		end
		if (state == CH_IDLE && key_done) begin
			s0_r <= key_in.sigma.sigma0;
			count_r <= key_in.count;
			present_r <= key_in.present;
		end
	end

endmodule

/* rtl/bch_loopback.sv */
module bch_loopback import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input data_t data_in,
	input code_t error,
	output logic busy,
	output logic done,
	output dec_result_t result
);

	logic bit_valid;
	logic code_bit;
	code_t err_r;
	logic rx_valid;
	logic rx_bit;
	logic syn_done;
	syn_result_t syn_res;
	logic key_done;
	key_result_t key_res;

	bch_encode i_encode (
		.clk(clk),
		.reset(reset),
		.start(start),
		.data_in(data_in),
		.busy(busy),
		.bit_valid(bit_valid),
		.code_bit(code_bit)
	);

	// channel model, one error bit per coded bit.
	always_ff @(posedge clk) begin
		if (start && !busy)
			err_r <= error;
		else if (bit_valid)
			err_r <= {err_r[CODE_N-2:0], 1'b0};
	end

	assign rx_valid = bit_valid;
	assign rx_bit = code_bit ^ err_r[CODE_N-1];

	bch_syndrome i_syndrome (
		.clk(clk),
		.reset(reset),
		.rx_valid(rx_valid),
		.rx_bit(rx_bit),
		.syn_done(syn_done),
		.syn_out(syn_res)
	);

	bch_key i_key (
		.clk(clk),
		.reset(reset),
		.syn_done(syn_done),
		.syn_in(syn_res),
		.key_done(key_done),
		.key_out(key_res)
	);

	bch_chien i_chien (
		.clk(clk),
		.reset(reset),
		.key_done(key_done),
		.key_in(key_res),
		.done(done),
		.result(result)
	);

endmodule

/* sim/bch_ref.svh */
`ifndef BCH_REF_SVH
`define BCH_REF_SVH

// x^10 + x^8 + x^5 + x^4 + x^2 + x + 1.
localparam logic [10:0] REF_GEN = 11'b101_0011_0111;

// systematic codeword: data in bits 14 to 10, remainder of d(x)*x^10 below.
function automatic code_t ref_codeword(input data_t d);
	logic [14:0] r;
	r = {d, 10'b0};
	for (int i = 14; i >= 10; i--) begin
		if (r[i])
			r ^= 15'(REF_GEN) << (i - 10);
	end
	return {d, r[9:0]};
endfunction

function automatic int popcount(input code_t v);
	int n;
	n = 0;
	for (int i = 0; i < 15; i++)
		n += v[i];
	return n;
endfunction

// distinct random bit positions until the weight is reached.
function automatic code_t random_pattern(input int weight);
	code_t p;
	int pos;
	p = '0;
	while (popcount(p) < weight) begin
		pos = $urandom_range(14, 0);
		p[pos] = 1'b1;
	end
	return p;
endfunction

function automatic data_t random_data();
	return data_t'($urandom_range(31, 0));
endfunction

`endif

/* sim/tb_bch_loopback.sv */
module tb_bch_loopback import bch_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_WORDS = 32 + 15 + 40 + 4 + 10 + 32;
	localparam int TIMEOUT_CYCLES = (40 + 100) * NUM_WORDS;

	logic clk;
	logic reset;
	logic start;
	data_t data_in;
	code_t error;
	logic busy;
	logic done;
	dec_result_t result;

	`include "bch_ref.svh"

	bch_loopback i_dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.data_in(data_in),
		.error(error),
		.busy(busy),
		.done(done),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_now($sformatf("error: %s is 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic check_result(input data_t d, input int w);
		check("result.data", result.data, d);
		check("result.count", result.count, w);
		check("result.present", result.present, w != 0);
		check("result.fail", result.fail, 0);
	endtask

	// one word through the loopback, optional stray start while busy.
	task automatic send_word(input data_t d, input code_t err, input int w, input int stray_at);
		int n;
		start = 1'b1;
		data_in = d;
		error = err;
		next_cycle();
		start = 1'b0;
		n = 1;
		check("busy", busy, 1);
		while (!done && n < 60) begin
			if (n == stray_at) begin
				start = 1'b1;
				data_in = ~d;
				error = 15'h7fff;
			end else begin
				start = 1'b0;
			end
			next_cycle();
			n++;
			if (n <= 15)
				check("busy", busy, 1);
			else if (n == 16)
				check("busy", busy, 0);
		end
		if (!done)
			fail_now("done did not rise within 60 cycles of an accepted start");
		check("done latency", n, 38);
		check_result(d, w);
		next_cycle();
		check("done", done, 0); // single-cycle strobe.
	endtask

	task automatic no_error_words();
		for (int i = 0; i < 32; i++)
			send_word(data_t'(i), '0, 0, 0);
	endtask

	task automatic single_error_words();
		for (int pos = 0; pos < 15; pos++)
			send_word(random_data(), code_t'(1) << pos, 1, 0);
	endtask

	task automatic double_triple_errors();
		int w;
		for (int i = 0; i < 40; i++) begin
			w = $urandom_range(3, 2);
			send_word(random_data(), random_pattern(w), w, 0);
		end
	endtask

	task automatic latency_and_busy();
		int stray [4];
		stray = '{1, 6, 11, 15};
		for (int i = 0; i < 4; i++) begin
			send_word(random_data(), random_pattern(i), i, stray[i]);
			for (int c = 0; c < 44; c++) begin
				next_cycle();
				check("done after ignored start", done, 0);
			end
		end
	endtask

	task automatic back_to_back();
		data_t q_data [$];
		int q_cnt [$];
		int q_time [$];
		data_t d;
		int w;
		int sent;
		int got;
		sent = 0;
		got = 0;
		for (int c = 0; c < 10 * 16 + 40; c++) begin
			if (c % 16 == 0 && sent < 10) begin
				w = sent % 4;
				d = random_data();
				start = 1'b1;
				data_in = d;
				error = random_pattern(w);
				q_data.push_back(d);
				q_cnt.push_back(w);
				q_time.push_back(c);
				sent++;
			end else begin
				start = 1'b0;
			end
			next_cycle();
			if (done) begin
				if (q_data.size() == 0)
					fail_now("done appeared with no word pending in the pipeline");
				check("pipelined latency", c + 1 - q_time.pop_front(), 38);
				check_result(q_data.pop_front(), q_cnt.pop_front());
				got++;
			end
		end
		check("pipelined words", got, 10);
	endtask

	// received word ends up with the data and an all-zero parity.
	task automatic parity_only_errors();
		code_t err;
		int p;
		for (int i = 0; i < 32; i++) begin
			err = ref_codeword(data_t'(i)) & 15'h03ff;
			p = popcount(err);
			if (p <= 3)
				send_word(data_t'(i), err, p, 0);
		end
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				fail_now($sformatf("timeout: no end of test after %0d cycles", cycles));
		end
	end

	initial begin
		reset = 1'b1;
		start = 1'b0;
		data_in = '0;
		error = '0;
		void'($urandom(29061));
		repeat (3) next_cycle();
		reset = 1'b0;
		check("busy", busy, 0);
		check("done", done, 0);
		check("result", result, 0);
		next_cycle();
		no_error_words();
		single_error_words();
		double_triple_errors();
		latency_and_busy();
		back_to_back();
		parity_only_errors();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* project.f */
+incdir+sim
rtl/bch_pkg.sv
rtl/bch_encode.sv
rtl/bch_syndrome.sv
rtl/bch_key.sv
rtl/bch_chien.sv
rtl/bch_loopback.sv
sim/tb_bch_loopback.sv
